//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////
    // Cache geometry
    ////////////////////
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int LINE_W   = 256;
    localparam int BEATS    = LINE_W / DATA_W;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 5;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS     = 2 ** INDEX_W;
    localparam int STRB_W   = DATA_W / 8;

    // Address field positions
    localparam int WORD_LSB   = 3;
    localparam int INDEX_LSB  = OFFSET_W;
    localparam int TAG_LSB    = OFFSET_W + INDEX_W;
    localparam int WORD_SEL_W = OFFSET_W - WORD_LSB;
    localparam int BEAT_W     = $clog2(BEATS);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [STRB_W-1:0]  strobe_t;
    typedef logic [1:0]         size_t;

    // Access sizes as encoded on i_size
    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;
    localparam size_t SIZE_D = 2'd3;

    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        MEM_REQ      = 2'd1,
        UPDATE_CACHE = 2'd2,
        MEM_WRITE    = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/dcache_array_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dcache_array_if;

    logic                                 rd_en;
    logic                                 wr_en;
    logic                                 block_replace;
    dcache_pkg::index_t                   index;
    logic [dcache_pkg::WORD_SEL_W-1:0]    word_sel;
    logic [dcache_pkg::WORD_LSB-1:0]      byte_off;
    dcache_pkg::size_t                    size;
    // Store data and strobe already sit in their byte lanes
    dcache_pkg::data_t                    wdata;
    dcache_pkg::strobe_t                  wstrb;

    modport ctrl (
        output rd_en, wr_en, block_replace, index, word_sel, byte_off, size, wdata, wstrb
    );

    modport array (
        input rd_en, wr_en, block_replace, index, word_sel, byte_off, size, wdata, wstrb
    );

endinterface

`default_nettype wire

//--- design/dcache_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dcache_mem_if;

    // Line refill request
    logic                 read_req;
    dcache_pkg::addr_t    read_addr;
    logic                 read_done;

    // Single write-through beat
    logic                 write_valid;
    dcache_pkg::addr_t    write_addr;
    dcache_pkg::data_t    write_data;
    dcache_pkg::strobe_t  write_strobe;
    logic                 write_done;

    modport master (
        output read_req, read_addr, write_valid, write_addr, write_data, write_strobe,
        input  read_done, write_done
    );

    modport slave (
        input  read_req, read_addr, write_valid, write_addr, write_data, write_strobe,
        output read_done, write_done
    );

endinterface

`default_nettype wire

//--- design/dcache_controller.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_controller (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_read,
    input  logic                   i_write,
    input  logic                   i_lr,
    input  logic                   i_sc,
    input  dcache_pkg::size_t      i_size,
    input  dcache_pkg::addr_t      i_addr,
    input  dcache_pkg::data_t      i_wdata,
    output logic                   o_stall,
    output logic                   o_load_fault,
    output logic                   o_store_fault,
    output dcache_pkg::data_t      o_sc_result,
    dcache_array_if.ctrl           arr,
    dcache_mem_if.master           mem
);

    dcache_pkg::ctrl_state_t state, next_state;

    dcache_pkg::tag_t tag_mem [dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0] valid_mem;

    logic              res_valid, next_res_valid;
    dcache_pkg::addr_t res_addr, next_res_addr;
    dcache_pkg::size_t res_size, next_res_size;

    dcache_pkg::tag_t                 addr_tag;
    dcache_pkg::index_t               addr_index;
    logic [dcache_pkg::WORD_LSB-1:0]  byte_off;
    dcache_pkg::strobe_t              base_strb;

    logic tag_hit;
    logic fault;
    logic res_match;
    logic update_en;

    assign addr_tag   = i_addr[dcache_pkg::ADDR_W-1:dcache_pkg::TAG_LSB];
    assign addr_index = i_addr[dcache_pkg::TAG_LSB-1:dcache_pkg::INDEX_LSB];
    assign byte_off   = i_addr[dcache_pkg::WORD_LSB-1:0];

    ////////////////////
    // Tag and valid store
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (update_en) begin
            tag_mem[addr_index] <= addr_tag;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= dcache_pkg::IDLE;
            valid_mem <= '0;
            res_valid <= 1'b0;
            res_addr  <= '0;
            res_size  <= '0;
        end else begin
            state     <= next_state;
            res_valid <= next_res_valid;
            res_addr  <= next_res_addr;
            res_size  <= next_res_size;
            if (update_en) begin
                valid_mem[addr_index] <= 1'b1;
            end
        end
    end

    assign tag_hit   = valid_mem[addr_index] && (tag_mem[addr_index] == addr_tag);
    assign res_match = res_valid && (res_addr == i_addr) && (res_size == i_size);

    // Misalignment, with the tighter rule for LR and SC
    always_comb begin
        case (i_size)
            dcache_pkg::SIZE_H: fault = (byte_off == 3'd7);
            dcache_pkg::SIZE_W: fault = (byte_off > 3'd4);
            dcache_pkg::SIZE_D: fault = (byte_off != 3'd0);
            default:            fault = 1'b0;
        endcase
        if (i_lr || i_sc) begin
            fault = !(((i_size == dcache_pkg::SIZE_W) && (byte_off[1:0] == 2'b00)) ||
                      ((i_size == dcache_pkg::SIZE_D) && (byte_off == 3'd0)));
        end
    end

    assign o_load_fault  = fault && (i_read || i_lr);
    assign o_store_fault = fault && (i_write || i_sc);

    // Strobe for the access size, moved to its byte lane
    always_comb begin
        case (i_size)
            dcache_pkg::SIZE_B: base_strb = 8'h01;
            dcache_pkg::SIZE_H: base_strb = 8'h03;
            dcache_pkg::SIZE_W: base_strb = 8'h0f;
            default:            base_strb = 8'hff;
        endcase
    end

    assign arr.index    = addr_index;
    assign arr.word_sel = i_addr[dcache_pkg::INDEX_LSB-1:dcache_pkg::WORD_LSB];
    assign arr.byte_off = byte_off;
    assign arr.size     = i_size;
    assign arr.wstrb    = base_strb << byte_off;
    assign arr.wdata    = i_wdata << {byte_off, 3'b000};

    assign mem.read_addr    = {i_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                               {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem.write_addr   = {i_addr[dcache_pkg::ADDR_W-1:dcache_pkg::WORD_LSB],
                               {dcache_pkg::WORD_LSB{1'b0}}};
    assign mem.write_data   = arr.wdata;
    assign mem.write_strobe = arr.wstrb;

    ////////////////////
    // Main FSM
    ////////////////////
    always_comb begin
        next_state        = state;
        next_res_valid    = res_valid;
        next_res_addr     = res_addr;
        next_res_size     = res_size;
        o_stall           = 1'b0;
        o_sc_result       = '0;
        arr.rd_en         = 1'b0;
        arr.wr_en         = 1'b0;
        arr.block_replace = 1'b0;
        mem.read_req      = 1'b0;
        mem.write_valid   = 1'b0;
        update_en         = 1'b0;

        case (state)
            dcache_pkg::IDLE: begin
                if (fault && (i_read || i_lr || i_sc || i_write)) begin
                    // Faults finish at once, a faulting SC also reports failure
                    o_sc_result = dcache_pkg::data_t'(i_sc);
                end else if ((i_read || i_lr || i_write || i_sc) && !tag_hit) begin
                    // Allocate on any miss, then retry from IDLE
                    o_stall      = 1'b1;
                    mem.read_req = 1'b1;
                    next_state   = dcache_pkg::MEM_REQ;
                end else if (i_read) begin
                    arr.rd_en = 1'b1;
                end else if (i_lr) begin
                    arr.rd_en      = 1'b1;
                    next_res_valid = 1'b1;
                    next_res_addr  = i_addr;
                    next_res_size  = i_size;
                end else if (i_write || (i_sc && res_match)) begin
                    arr.wr_en       = 1'b1;
                    mem.write_valid = 1'b1;
                    o_stall         = 1'b1;
                    next_state      = dcache_pkg::MEM_WRITE;
                    if (i_sc) begin
                        next_res_valid = 1'b0;
                    end
                end else if (i_sc) begin
                    next_res_valid = 1'b0;
                    o_sc_result    = dcache_pkg::data_t'(1);
                end
            end

            dcache_pkg::MEM_REQ: begin
                o_stall      = 1'b1;
                mem.read_req = 1'b1;
                if (mem.read_done) begin
                    mem.read_req = 1'b0;
                    next_state   = dcache_pkg::UPDATE_CACHE;
                end
            end

            dcache_pkg::UPDATE_CACHE: begin
                o_stall           = 1'b1;
                arr.block_replace = 1'b1;
                update_en         = 1'b1;
                next_state        = dcache_pkg::IDLE;
            end

            dcache_pkg::MEM_WRITE: begin
                o_stall         = 1'b1;
                mem.write_valid = 1'b1;
                // Request completes in the write_done cycle
                if (mem.write_done) begin
                    o_stall         = 1'b0;
                    mem.write_valid = 1'b0;
                    next_state      = dcache_pkg::IDLE;
                end
            end

            default: next_state = dcache_pkg::IDLE;
        endcase
    end

    ////////////////////
    // Checks
    ////////////////////
    // The refill address must not move while the line is fetched
    a_stall_in_refill: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (state == dcache_pkg::MEM_REQ) |-> (o_stall && $stable(mem.read_addr))
    );

    // A done pulse belongs to the request that is outstanding
    a_done_matches_request: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(mem.read_done && (state != dcache_pkg::MEM_REQ)) &&
        !(mem.write_done && (state != dcache_pkg::MEM_WRITE))
    );

endmodule

`default_nettype wire

//--- design/dcache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_data_array (
    input  logic                i_clk,
    input  logic                i_rst_n,
    dcache_array_if.array       arr,
    input  dcache_pkg::line_t   i_refill_line,
    output dcache_pkg::data_t   o_rdata
);

    dcache_pkg::line_t line_mem [dcache_pkg::SETS];

    dcache_pkg::data_t cur_word;
    dcache_pkg::data_t shifted;
    dcache_pkg::data_t load_val;

    // Refill replaces the whole line, a store merges bytes into one word
    always_ff @(posedge i_clk) begin
        if (arr.block_replace) begin
            line_mem[arr.index] <= i_refill_line;
        end else if (arr.wr_en) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (arr.wstrb[b]) begin
                    line_mem[arr.index][arr.word_sel*dcache_pkg::DATA_W + b*8 +: 8] <=
                        arr.wdata[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // Load lane extraction
    ////////////////////
    assign cur_word = line_mem[arr.index][arr.word_sel*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];
    assign shifted  = cur_word >> {arr.byte_off, 3'b000};

    always_comb begin
        case (arr.size)
            dcache_pkg::SIZE_B: load_val = {56'd0, shifted[7:0]};
            dcache_pkg::SIZE_H: load_val = {48'd0, shifted[15:0]};
            dcache_pkg::SIZE_W: load_val = {32'd0, shifted[31:0]};
            default:            load_val = shifted;
        endcase
    end

    // Only a hit read drives the load bus
    assign o_rdata = arr.rd_en ? load_val : '0;

    a_no_read_during_write: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        arr.rd_en |-> !(arr.wr_en || arr.block_replace)
    );

endmodule

`default_nettype wire

//--- design/dcache_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_port (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    dcache_mem_if.slave           mem,
    output dcache_pkg::line_t     o_refill_line,
    output logic                  o_mem_req,
    output logic                  o_mem_we,
    output dcache_pkg::addr_t     o_mem_addr,
    output dcache_pkg::data_t     o_mem_wdata,
    output dcache_pkg::strobe_t   o_mem_strb,
    input  logic                  i_mem_ack,
    input  dcache_pkg::data_t     i_mem_rdata
);

    logic                          rd_busy;
    logic                          wr_busy;
    logic [dcache_pkg::BEAT_W-1:0] beat_cnt;
    dcache_pkg::line_t             line_q;

    ////////////////////
    // Beat sequencing
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_busy        <= 1'b0;
            wr_busy        <= 1'b0;
            beat_cnt       <= '0;
            mem.read_done  <= 1'b0;
            mem.write_done <= 1'b0;
        end else begin
            mem.read_done  <= 1'b0;
            mem.write_done <= 1'b0;
            if (rd_busy) begin
                if (i_mem_ack) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt == dcache_pkg::BEAT_W'(dcache_pkg::BEATS - 1)) begin
                        rd_busy       <= 1'b0;
                        mem.read_done <= 1'b1;
                    end
                end
            end else if (wr_busy) begin
                if (i_mem_ack) begin
                    wr_busy        <= 1'b0;
                    mem.write_done <= 1'b1;
                end
            end else if (mem.read_req) begin
                rd_busy  <= 1'b1;
                beat_cnt <= '0;
            end else if (mem.write_valid) begin
                wr_busy <= 1'b1;
            end
        end
    end

    // Pack returned beats into the refill line
    always_ff @(posedge i_clk) begin
        if (rd_busy && i_mem_ack) begin
            line_q[beat_cnt*dcache_pkg::DATA_W +: dcache_pkg::DATA_W] <= i_mem_rdata;
        end
    end

    assign o_refill_line = line_q;
    assign o_mem_req     = rd_busy || wr_busy;
    assign o_mem_we      = wr_busy;
    assign o_mem_addr    = rd_busy ?
        {mem.read_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], beat_cnt,
         {dcache_pkg::WORD_LSB{1'b0}}} :
        mem.write_addr;
    assign o_mem_wdata   = mem.write_data;
    assign o_mem_strb    = wr_busy ? mem.write_strobe : '0;

    a_addr_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_mem_req && !i_mem_ack) |=> $stable(o_mem_addr)
    );

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Core side
    input  logic                  i_read,
    input  logic                  i_write,
    input  logic                  i_lr,
    input  logic                  i_sc,
    input  dcache_pkg::size_t     i_size,
    input  dcache_pkg::addr_t     i_addr,
    input  dcache_pkg::data_t     i_wdata,
    output dcache_pkg::data_t     o_rdata,
    output logic                  o_stall,
    output logic                  o_load_fault,
    output logic                  o_store_fault,
    output dcache_pkg::data_t     o_sc_result,

    // Memory side
    output logic                  o_mem_req,
    output logic                  o_mem_we,
    output dcache_pkg::addr_t     o_mem_addr,
    output dcache_pkg::data_t     o_mem_wdata,
    output dcache_pkg::strobe_t   o_mem_strb,
    input  logic                  i_mem_ack,
    input  dcache_pkg::data_t     i_mem_rdata
);

    dcache_array_if    arr_if ();
    dcache_mem_if      mem_if ();
    dcache_pkg::line_t refill_line;

    dcache_controller u_controller (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_lr          (i_lr),
        .i_sc          (i_sc),
        .i_size        (i_size),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_stall       (o_stall),
        .o_load_fault  (o_load_fault),
        .o_store_fault (o_store_fault),
        .o_sc_result   (o_sc_result),
        .arr           (arr_if.ctrl),
        .mem           (mem_if.master)
    );

    dcache_data_array u_data_array (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .arr           (arr_if.array),
        .i_refill_line (refill_line),
        .o_rdata       (o_rdata)
    );

    dcache_mem_port u_mem_port (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .mem           (mem_if.slave),
        .o_refill_line (refill_line),
        .o_mem_req     (o_mem_req),
        .o_mem_we      (o_mem_we),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .o_mem_strb    (o_mem_strb),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata)
    );

endmodule

`default_nettype wire

//--- test/dcache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_checker #(
    parameter int SAMPLE_DELAY = 10
) (
    input wire logic                i_clk,
    input wire logic                i_rst_n,
    input wire logic                i_read,
    input wire logic                i_write,
    input wire logic                i_lr,
    input wire logic                i_sc,
    input wire dcache_pkg::size_t   i_size,
    input wire dcache_pkg::addr_t   i_addr,
    input wire dcache_pkg::data_t   i_wdata,
    input wire dcache_pkg::data_t   i_rdata,
    input wire logic                i_stall,
    input wire logic                i_load_fault,
    input wire logic                i_store_fault,
    input wire dcache_pkg::data_t   i_sc_result,
    input wire logic                i_mem_req,
    input wire logic                i_mem_we,
    input wire dcache_pkg::addr_t   i_mem_addr,
    input wire dcache_pkg::data_t   i_mem_wdata,
    input wire dcache_pkg::strobe_t i_mem_strb,
    input wire logic                i_mem_ack
);

    int err_count = 0;

    logic [7:0]        mem_bytes [int unsigned];
    logic              res_valid = 1'b0;
    dcache_pkg::addr_t res_addr;
    dcache_pkg::size_t res_size;
    int unsigned       beat = 0;
    int unsigned       wr_beats = 0;

    // Same pattern as the memory responder, one byte at a time
    function automatic logic [7:0] read_byte(input logic [31:0] a);
        logic [63:0] w;
        logic [31:0] wa;
        if (mem_bytes.exists(a)) begin
            return mem_bytes[a];
        end
        wa = {a[31:3], 3'b000};
        w  = {wa ^ 32'h5a5a_0f0f, wa * 32'h9e37_79b9 + 32'h1234_5678};
        return w[a[2:0]*8 +: 8];
    endfunction

    function automatic logic misaligned(input logic [1:0] s, input logic [2:0] off,
                                        input logic atomic);
        if (atomic) begin
            return !((s == 2'd2 && off[1:0] == 2'b00) || (s == 2'd3 && off == 3'd0));
        end
        // Plain accesses may start anywhere inside their doubleword
        return ({1'b0, off} + 4'(1 << s)) > 4'd8;
    endfunction

    task automatic value_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
        $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic protocol_problem(input string msg);
        $display("At %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic sample_cycle();
        logic        flt;
        logic        match;
        logic [2:0]  off;
        logic [63:0] exp;
        logic [7:0]  strb;
        off   = i_addr[2:0];
        flt   = misaligned(i_size, off, i_lr || i_sc);
        match = res_valid && res_addr == i_addr && res_size == i_size;
        strb  = 8'((16'h1 << (1 << i_size)) - 1) << off;
        if (!(i_read || i_write || i_lr || i_sc)) begin
            if (i_mem_req) protocol_problem("memory request without a core request");
            return;
        end
        if (flt && (i_stall || i_mem_req)) begin
            protocol_problem("misaligned access stalled or reached memory");
        end
        if (i_mem_req && i_mem_ack) begin
            if (i_mem_we) begin
                wr_beats++;
                if (!(i_write || i_sc) || flt) protocol_problem("unexpected memory write");
                if (i_mem_addr !== {i_addr[31:3], 3'b000})
                    value_mismatch("o_mem_addr", {i_addr[31:3], 3'b000}, i_mem_addr);
                // Store bytes sit in the lanes their address selects
                for (int i = 0; i < (1 << i_size); i++) begin
                    if (i_mem_wdata[(off + i)*8 +: 8] !== i_wdata[i*8 +: 8])
                        value_mismatch("o_mem_wdata", i_wdata[i*8 +: 8],
                                       i_mem_wdata[(off + i)*8 +: 8]);
                end
                if (i_mem_strb !== strb) value_mismatch("o_mem_strb", strb, i_mem_strb);
            end else begin
                exp = {32'd0, i_addr[31:5], 2'(beat), 3'b000};
                if (i_mem_addr !== exp[31:0]) value_mismatch("o_mem_addr", exp, i_mem_addr);
                beat++;
            end
        end
        if (i_stall) return;

        // Request completes in this cycle
        if (beat != 0 && beat != dcache_pkg::BEATS)
            protocol_problem("line refill did not make four read beats");
        if (i_load_fault !== (flt && (i_read || i_lr)))
            value_mismatch("o_load_fault", flt && (i_read || i_lr), i_load_fault);
        if (i_store_fault !== (flt && (i_write || i_sc)))
            value_mismatch("o_store_fault", flt && (i_write || i_sc), i_store_fault);
        if (i_sc) begin
            exp = (flt || !match) ? 64'd1 : 64'd0;
            if (i_sc_result !== exp) value_mismatch("o_sc_result", exp, i_sc_result);
        end
        if (!flt && (i_read || i_lr)) begin
            exp = '0;
            for (int i = 0; i < (1 << i_size); i++) exp[i*8 +: 8] = read_byte(i_addr + i);
            if (i_rdata !== exp) value_mismatch("o_rdata", exp, i_rdata);
        end
        if (!flt && i_lr) begin
            res_valid = 1'b1;
            res_addr  = i_addr;
            res_size  = i_size;
        end
        if (!flt && (i_write || (i_sc && match))) begin
            if (wr_beats != 1) protocol_problem("store did not make exactly one write beat");
            for (int i = 0; i < (1 << i_size); i++) mem_bytes[i_addr + i] = i_wdata[i*8 +: 8];
        end else if (wr_beats != 0) begin
            protocol_problem("write beat for a request that writes nothing");
        end
        if (!flt && i_sc) res_valid = 1'b0;
        beat     = 0;
        wr_beats = 0;
    endtask

    ////////////////////
    // Sample between edges
    ////////////////////
    always @(negedge i_clk) begin
        #(SAMPLE_DELAY);
        if (!i_rst_n) begin
            if (i_stall !== 1'b0 || i_mem_req !== 1'b0)
                protocol_problem("o_stall or o_mem_req high during reset");
            res_valid = 1'b0;
            beat      = 0;
            wr_beats  = 0;
        end else begin
            sample_cycle();
        end
    end

endmodule

`default_nettype wire

//--- test/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int          PERIOD   = 40;
    localparam int          NUM_REQ  = 3000;
    localparam logic [31:0] SEED     = 32'h904d_ad1f;
    localparam logic [31:0] WIN_BASE = 32'h0000_8000;

    logic                i_clk     = 1'b0;
    logic                i_rst_n   = 1'b0;
    logic                i_read    = 1'b0;
    logic                i_write   = 1'b0;
    logic                i_lr      = 1'b0;
    logic                i_sc      = 1'b0;
    dcache_pkg::size_t   i_size    = '0;
    dcache_pkg::addr_t   i_addr    = '0;
    dcache_pkg::data_t   i_wdata   = '0;
    logic                i_mem_ack = 1'b0;
    dcache_pkg::data_t   i_mem_rdata = '0;
    dcache_pkg::data_t   o_rdata;
    dcache_pkg::data_t   o_sc_result;
    logic                o_stall;
    logic                o_load_fault;
    logic                o_store_fault;
    logic                o_mem_req;
    logic                o_mem_we;
    dcache_pkg::addr_t   o_mem_addr;
    dcache_pkg::data_t   o_mem_wdata;
    dcache_pkg::strobe_t o_mem_strb;

    logic [63:0]       mem_words [int unsigned];
    int unsigned       ack_wait = 0;
    logic              lr_seen  = 1'b0;
    dcache_pkg::addr_t lr_addr;
    dcache_pkg::size_t lr_size;

    dcache_top i_dut (
        .i_clk, .i_rst_n, .i_read, .i_write, .i_lr, .i_sc, .i_size, .i_addr, .i_wdata,
        .o_rdata, .o_stall, .o_load_fault, .o_store_fault, .o_sc_result,
        .o_mem_req, .o_mem_we, .o_mem_addr, .o_mem_wdata, .o_mem_strb,
        .i_mem_ack, .i_mem_rdata
    );

    dcache_checker #(.SAMPLE_DELAY(PERIOD / 4)) i_chk (
        .i_clk, .i_rst_n, .i_read, .i_write, .i_lr, .i_sc, .i_size, .i_addr, .i_wdata,
        .i_rdata(o_rdata), .i_stall(o_stall), .i_load_fault(o_load_fault),
        .i_store_fault(o_store_fault), .i_sc_result(o_sc_result),
        .i_mem_req(o_mem_req), .i_mem_we(o_mem_we), .i_mem_addr(o_mem_addr),
        .i_mem_wdata(o_mem_wdata), .i_mem_strb(o_mem_strb), .i_mem_ack(i_mem_ack)
    );

    initial begin
        forever #(PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [63:0] fill_word(input logic [31:0] wa);
        return {wa ^ 32'h5a5a_0f0f, wa * 32'h9e37_79b9 + 32'h1234_5678};
    endfunction

    ////////////////////
    // Memory responder
    ////////////////////
    always @(negedge i_clk) begin
        logic [63:0] w;
        if (!i_rst_n) begin
            i_mem_ack = 1'b0;
        end else if (i_mem_ack) begin
            i_mem_ack = 1'b0;
            ack_wait  = $urandom_range(3, 0);
        end else if (o_mem_req) begin
            if (ack_wait == 0) begin
                w = mem_words.exists(o_mem_addr) ? mem_words[o_mem_addr] : fill_word(o_mem_addr);
                if (o_mem_we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (o_mem_strb[b]) w[b*8 +: 8] = o_mem_wdata[b*8 +: 8];
                    end
                    mem_words[o_mem_addr] = w;
                end
                i_mem_rdata = w;
                i_mem_ack   = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic idle_inputs();
        i_read  = 1'b0;
        i_write = 1'b0;
        i_lr    = 1'b0;
        i_sc    = 1'b0;
    endtask

    task automatic drive_request();
        int unsigned kind;
        int unsigned off;
        dcache_pkg::size_t sz;
        kind = $urandom_range(9, 0);
        sz   = dcache_pkg::size_t'($urandom_range(3, 0));
        off  = $urandom_range(7, 0);
        // Mostly aligned, sometimes any offset
        if ($urandom_range(3, 0) != 0) off = off & ~((1 << sz) - 1);
        idle_inputs();
        i_size  = sz;
        i_addr  = WIN_BASE + $urandom_range(63, 0) * 32 + $urandom_range(3, 0) * 8 + off;
        i_wdata = {$urandom, $urandom};
        if (kind <= 3) begin
            i_read = 1'b1;
        end else if (kind <= 6) begin
            i_write = 1'b1;
        end else if (kind == 7) begin
            i_lr    = 1'b1;
            lr_seen = 1'b1;
            lr_addr = i_addr;
            lr_size = i_size;
        end else begin
            i_sc = 1'b1;
            if (lr_seen && $urandom_range(3, 0) != 0) begin
                i_addr = lr_addr;
                i_size = lr_size;
            end
        end
    endtask

    // Ends on the falling edge after the completing cycle
    task automatic wait_complete();
        logic done;
        done = 1'b0;
        while (!done) begin
            #(PERIOD / 4);
            done = !o_stall;
            @(negedge i_clk);
        end
    endtask

    initial begin
        #(NUM_REQ * 200 * PERIOD);
        $display("Watchdog expired before all requests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            drive_request();
            wait_complete();
            if ($urandom_range(3, 0) == 0) begin
                idle_inputs();
                @(negedge i_clk);
            end
        end
        idle_inputs();
        repeat (4) @(negedge i_clk);
        $display("Requests: %0d, errors: %0d", NUM_REQ, i_chk.err_count);
        if (i_chk.err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
design/dcache_pkg.sv
design/dcache_array_if.sv
design/dcache_mem_if.sv
design/dcache_controller.sv
design/dcache_data_array.sv
design/dcache_mem_port.sv
design/dcache_top.sv
test/dcache_checker.sv
test/dcache_tb.sv

//--- Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
